/* hdl/exec_lane.sv */
`default_nettype none

module exec_lane (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            issue_valid,
    input  wire issue_pkg::op_e                  issue_op,
    input  wire logic [issue_pkg::reg_idx_w-1:0] issue_rd,
    input  wire logic [issue_pkg::imm_w-1:0]     issue_imm,
    input  wire logic [issue_pkg::tag_w-1:0]     issue_tag,
    input  wire logic [issue_pkg::data_w-1:0]    opnd_a,
    input  wire logic [issue_pkg::data_w-1:0]    opnd_b,
    input  wire logic [issue_pkg::data_w-1:0]    mul_product,
    output logic                                 ex_valid,
    output logic [issue_pkg::reg_idx_w-1:0]      ex_rd,
    output logic                                 ex_wen,
    output logic [issue_pkg::data_w-1:0]         ex_result,
    output logic                                 ex_is_mul,
    output logic                                 ret_valid,
    output logic [issue_pkg::tag_w-1:0]          ret_tag,
    output logic [issue_pkg::reg_idx_w-1:0]      ret_rd,
    output logic                                 ret_wen,
    output logic [issue_pkg::data_w-1:0]         ret_value
);
    import issue_pkg::*;

    op_e               ex_op;
    logic [imm_w-1:0]  ex_imm;
    logic [tag_w-1:0]  ex_tag;
    logic [data_w-1:0] ex_a;
    logic [data_w-1:0] ex_b;
    logic [data_w-1:0] wb_alu;
    logic              wb_is_mul;

    // execute register
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= issue_valid;
        end
        ex_op  <= issue_op;
        ex_rd  <= issue_rd;
        ex_imm <= issue_imm;
        ex_tag <= issue_tag;
        ex_a   <= opnd_a;
        ex_b   <= opnd_b;
    end

    always_comb begin
        case (ex_op)
            op_add:  ex_result = ex_a + ex_b;
            op_sub:  ex_result = ex_a - ex_b;
            op_and:  ex_result = ex_a & ex_b;
            op_or:   ex_result = ex_a | ex_b;
            op_xor:  ex_result = ex_a ^ ex_b;
            op_addi: ex_result = ex_a + {{(data_w - imm_w){ex_imm[imm_w-1]}}, ex_imm};
            op_lui:  ex_result = {ex_imm, {(data_w - imm_w){1'b0}}};
            default: ex_result = '0;
        endcase
    end

    assign ex_wen    = ex_valid && writes_reg(ex_op, ex_rd);
    assign ex_is_mul = is_mul(ex_op);

    // writeback register
    always_ff @(posedge clk) begin
        if (rst) begin
            ret_valid <= 1'b0;
            ret_wen   <= 1'b0;
        end else begin
            ret_valid <= ex_valid;
            ret_wen   <= ex_wen;
        end
        ret_tag   <= ex_tag;
        ret_rd    <= ex_rd;
        wb_alu    <= ex_result;
        wb_is_mul <= ex_is_mul;
    end

    // multiplier result lands here in the same cycle
    assign ret_value = wb_is_mul ? mul_product : wb_alu;

endmodule

`default_nettype wire

/* hdl/issue_core.sv */
`default_nettype none

module issue_core (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            flush,
    input  wire logic [1:0]                      in_valid,
    input  wire issue_pkg::op_e                  in_op     [1:0],
    input  wire logic [issue_pkg::reg_idx_w-1:0] in_rd     [1:0],
    input  wire logic [issue_pkg::reg_idx_w-1:0] in_rs1    [1:0],
    input  wire logic [issue_pkg::reg_idx_w-1:0] in_rs2    [1:0],
    input  wire logic [issue_pkg::imm_w-1:0]     in_imm    [1:0],
    input  wire logic [issue_pkg::tag_w-1:0]     in_tag    [1:0],
    output logic                                 in_ready,
    output logic [1:0]                           ret_valid,
    output logic [issue_pkg::tag_w-1:0]          ret_tag   [1:0],
    output logic [issue_pkg::reg_idx_w-1:0]      ret_rd    [1:0],
    output logic [1:0]                           ret_wen,
    output logic [issue_pkg::data_w-1:0]         ret_value [1:0]
);
    import issue_pkg::*;

    logic [1:0]           cand_ready;
    logic [1:0]           issue_valid;
    op_e                  issue_op    [1:0];
    logic [reg_idx_w-1:0] issue_rd    [1:0];
    logic [reg_idx_w-1:0] issue_rs1   [1:0];
    logic [reg_idx_w-1:0] issue_rs2   [1:0];
    logic [imm_w-1:0]     issue_imm   [1:0];
    logic [tag_w-1:0]     issue_tag   [1:0];
    logic [reg_idx_w-1:0] rf_raddr    [3:0];
    logic [data_w-1:0]    rf_rdata    [3:0];
    logic [data_w-1:0]    opnd_a      [1:0];
    logic [data_w-1:0]    opnd_b      [1:0];
    logic [1:0]           ex_valid;
    logic [reg_idx_w-1:0] ex_rd       [1:0];
    logic [1:0]           ex_wen;
    logic [data_w-1:0]    ex_result   [1:0];
    logic [1:0]           ex_is_mul;
    logic [data_w-1:0]    mul_product [1:0];

    issue_queue u_queue (
        .clk, .rst, .flush,
        .in_valid, .in_op, .in_rd, .in_rs1, .in_rs2, .in_imm, .in_tag,
        .cand_ready, .in_ready,
        .issue_valid, .issue_op, .issue_rd, .issue_rs1, .issue_rs2,
        .issue_imm, .issue_tag
    );

    operand_bypass u_bypass (
        .cand_rs1 (issue_rs1),
        .cand_rs2 (issue_rs2),
        .rf_rdata,
        .ex_valid, .ex_rd, .ex_wen, .ex_result, .ex_is_mul,
        .wb_valid (ret_valid),
        .wb_rd    (ret_rd),
        .wb_wen   (ret_wen),
        .wb_value (ret_value),
        .cand_ready, .opnd_a, .opnd_b
    );

    // write port per lane straight from writeback
    reg_file u_rf (
        .clk, .rst,
        .raddr (rf_raddr),
        .we    (ret_wen),
        .waddr (ret_rd),
        .wdata (ret_value),
        .rdata (rf_rdata)
    );

    mul_unit u_mul (
        .clk, .rst, .issue_valid, .issue_op, .opnd_a, .opnd_b, .mul_product
    );

    for (genvar l = 0; l < 2; l++) begin : g_lane
        assign rf_raddr[2*l]   = issue_rs1[l];
        assign rf_raddr[2*l+1] = issue_rs2[l];

        exec_lane u_lane (
            .clk, .rst,
            .issue_valid (issue_valid[l]),
            .issue_op    (issue_op[l]),
            .issue_rd    (issue_rd[l]),
            .issue_imm   (issue_imm[l]),
            .issue_tag   (issue_tag[l]),
            .opnd_a      (opnd_a[l]),
            .opnd_b      (opnd_b[l]),
            .mul_product (mul_product[l]),
            .ex_valid    (ex_valid[l]),
            .ex_rd       (ex_rd[l]),
            .ex_wen      (ex_wen[l]),
            .ex_result   (ex_result[l]),
            .ex_is_mul   (ex_is_mul[l]),
            .ret_valid   (ret_valid[l]),
            .ret_tag     (ret_tag[l]),
            .ret_rd      (ret_rd[l]),
            .ret_wen     (ret_wen[l]),
            .ret_value   (ret_value[l])
        );
    end

endmodule

`default_nettype wire

/* hdl/issue_pkg.sv */
`default_nettype none

package issue_pkg;

    localparam int queue_depth = 16;
    localparam int queue_idx_w = 4;
    localparam int reg_count   = 16;
    localparam int reg_idx_w   = 4;
    localparam int data_w      = 32;
    localparam int tag_w       = 8;
    localparam int imm_w       = 16;
    // multiplier operand halves
    localparam int half_w      = data_w / 2;

    typedef enum logic [3:0] {
        op_nop,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_addi,
        op_lui,
        op_mul
    } op_e;

    function automatic logic is_mul(op_e op);
        return op == op_mul;
    endfunction

    // r0 is never a real destination
    function automatic logic writes_reg(op_e op, logic [reg_idx_w-1:0] rd);
        return (op != op_nop) && (rd != '0);
    endfunction

endpackage

`default_nettype wire

/* hdl/issue_queue.sv */
`default_nettype none

module issue_queue (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                flush,
    input  wire logic [1:0]                          in_valid,
    input  wire issue_pkg::op_e                      in_op     [1:0],
    input  wire logic [issue_pkg::reg_idx_w-1:0]     in_rd     [1:0],
    input  wire logic [issue_pkg::reg_idx_w-1:0]     in_rs1    [1:0],
    input  wire logic [issue_pkg::reg_idx_w-1:0]     in_rs2    [1:0],
    input  wire logic [issue_pkg::imm_w-1:0]         in_imm    [1:0],
    input  wire logic [issue_pkg::tag_w-1:0]         in_tag    [1:0],
    input  wire logic [1:0]                          cand_ready,
    output logic                                     in_ready,
    output logic [1:0]                               issue_valid,
    output issue_pkg::op_e                           issue_op  [1:0],
    output logic [issue_pkg::reg_idx_w-1:0]          issue_rd  [1:0],
    output logic [issue_pkg::reg_idx_w-1:0]          issue_rs1 [1:0],
    output logic [issue_pkg::reg_idx_w-1:0]          issue_rs2 [1:0],
    output logic [issue_pkg::imm_w-1:0]              issue_imm [1:0],
    output logic [issue_pkg::tag_w-1:0]              issue_tag [1:0]
);
    import issue_pkg::*;

    typedef enum logic {
        st_direct,
        st_queued
    } sel_state_e;

    op_e                    q_op  [queue_depth];
    logic [reg_idx_w-1:0]   q_rd  [queue_depth];
    logic [reg_idx_w-1:0]   q_rs1 [queue_depth];
    logic [reg_idx_w-1:0]   q_rs2 [queue_depth];
    logic [imm_w-1:0]       q_imm [queue_depth];
    logic [tag_w-1:0]       q_tag [queue_depth];

    logic [queue_idx_w-1:0] head;
    logic [queue_idx_w-1:0] tail;
    logic [queue_idx_w-1:0] head_nx;
    logic [queue_idx_w:0]   count;
    logic [queue_idx_w:0]   count_nx;
    sel_state_e             state;

    logic [1:0]             accepted;
    logic [1:0]             cand_valid;
    logic                   c1_from_q;
    logic                   c0_from_q;
    logic                   c0_in_idx;
    logic                   raw_hazard;
    logic                   dual_mul;
    logic [1:0]             pop_cnt;
    logic [1:0]             used_in;
    logic [1:0]             enq_cnt;
    logic [1:0]             wr_en;
    logic [queue_idx_w-1:0] wr_idx [1:0];

    assign head_nx  = head + 1'b1;
    assign in_ready = (count <= queue_depth - 2);
    assign accepted = in_ready ? in_valid : 2'b00;

    // empty queue feeds decode straight through
    assign c1_from_q = (state == st_queued);
    assign c0_from_q = (count > 1);
    // one entry left pairs with the older incoming slot
    assign c0_in_idx = (count == 1);

    always_comb begin
        issue_op[1]  = c1_from_q ? q_op[head]  : in_op[1];
        issue_rd[1]  = c1_from_q ? q_rd[head]  : in_rd[1];
        issue_rs1[1] = c1_from_q ? q_rs1[head] : in_rs1[1];
        issue_rs2[1] = c1_from_q ? q_rs2[head] : in_rs2[1];
        issue_imm[1] = c1_from_q ? q_imm[head] : in_imm[1];
        issue_tag[1] = c1_from_q ? q_tag[head] : in_tag[1];
        issue_op[0]  = c0_from_q ? q_op[head_nx]  : in_op[c0_in_idx];
        issue_rd[0]  = c0_from_q ? q_rd[head_nx]  : in_rd[c0_in_idx];
        issue_rs1[0] = c0_from_q ? q_rs1[head_nx] : in_rs1[c0_in_idx];
        issue_rs2[0] = c0_from_q ? q_rs2[head_nx] : in_rs2[c0_in_idx];
        issue_imm[0] = c0_from_q ? q_imm[head_nx] : in_imm[c0_in_idx];
        issue_tag[0] = c0_from_q ? q_tag[head_nx] : in_tag[c0_in_idx];
        cand_valid[1] = c1_from_q || accepted[1];
        cand_valid[0] = c0_from_q || accepted[c0_in_idx];
    end

    // pairing rules for the younger candidate
    assign raw_hazard = writes_reg(issue_op[1], issue_rd[1]) &&
                        (issue_rd[1] == issue_rs1[0] || issue_rd[1] == issue_rs2[0]);
    assign dual_mul   = is_mul(issue_op[1]) && is_mul(issue_op[0]);

    assign issue_valid[1] = cand_valid[1] && cand_ready[1];
    assign issue_valid[0] = issue_valid[1] && cand_valid[0] && cand_ready[0] &&
                            !raw_hazard && !dual_mul;

    // split issued ops between queue pops and incoming slots
    always_comb begin
        if (state == st_direct) begin
            pop_cnt = 2'd0;
            used_in = 2'(issue_valid[1]) + 2'(issue_valid[0]);
        end else if (count == 1) begin
            pop_cnt = 2'(issue_valid[1]);
            used_in = 2'(issue_valid[0]);
        end else begin
            pop_cnt = 2'(issue_valid[1]) + 2'(issue_valid[0]);
            used_in = 2'd0;
        end
        enq_cnt  = 2'(accepted[1]) + 2'(accepted[0]) - used_in;
        count_nx = count - (queue_idx_w + 1)'(pop_cnt) + (queue_idx_w + 1)'(enq_cnt);
    end

    // leftovers go in behind the tail, older slot first
    assign wr_en[1]  = accepted[1] && (used_in == 2'd0);
    assign wr_en[0]  = accepted[0] && (used_in != 2'd2);
    assign wr_idx[1] = tail;
    assign wr_idx[0] = (used_in == 2'd0) ? tail + 1'b1 : tail;

    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            if (wr_en[s]) begin
                q_op[wr_idx[s]]  <= in_op[s];
                q_rd[wr_idx[s]]  <= in_rd[s];
                q_rs1[wr_idx[s]] <= in_rs1[s];
                q_rs2[wr_idx[s]] <= in_rs2[s];
                q_imm[wr_idx[s]] <= in_imm[s];
                q_tag[wr_idx[s]] <= in_tag[s];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            state <= st_direct;
        end else if (flush) begin
            // drop whatever is still waiting
            head  <= tail;
            count <= '0;
            state <= st_direct;
        end else begin
            head  <= head + queue_idx_w'(pop_cnt);
            tail  <= tail + queue_idx_w'(enq_cnt);
            count <= count_nx;
            state <= (count_nx == '0) ? st_direct : st_queued;
        end
    end

endmodule

`default_nettype wire

/* hdl/mul_unit.sv */
`default_nettype none

module mul_unit (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic [1:0]                   issue_valid,
    input  wire issue_pkg::op_e               issue_op    [1:0],
    input  wire logic [issue_pkg::data_w-1:0] opnd_a      [1:0],
    input  wire logic [issue_pkg::data_w-1:0] opnd_b      [1:0],
    output logic [issue_pkg::data_w-1:0]      mul_product [1:0]
);
    import issue_pkg::*;

    logic [1:0]          sel;
    logic                sel_lane;
    logic [half_w-1:0]   a_lo;
    logic [half_w-1:0]   a_hi;
    logic [half_w-1:0]   b_lo;
    logic [half_w-1:0]   b_hi;
    logic                s1_valid;
    logic                s1_lane;
    logic [data_w-1:0]   pp_ll;
    logic [data_w-1:0]   pp_lh;
    logic [data_w-1:0]   pp_hl;
    logic [data_w-1:0]   pp_hh;
    logic [2*data_w-1:0] sum;
    logic                s2_valid;
    logic                s2_lane;
    logic [data_w-1:0]   product;

    // pairing keeps this to one lane per cycle
    assign sel[1]   = issue_valid[1] && is_mul(issue_op[1]);
    assign sel[0]   = issue_valid[0] && is_mul(issue_op[0]);
    assign sel_lane = sel[1];

    assign a_lo = opnd_a[sel_lane][half_w-1:0];
    assign a_hi = opnd_a[sel_lane][data_w-1:half_w];
    assign b_lo = opnd_b[sel_lane][half_w-1:0];
    assign b_hi = opnd_b[sel_lane][data_w-1:half_w];

    assign sum = {{data_w{1'b0}}, pp_ll} +
                 {{half_w{1'b0}}, pp_lh, {half_w{1'b0}}} +
                 {{half_w{1'b0}}, pp_hl, {half_w{1'b0}}} +
                 {pp_hh, {data_w{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= |sel;
            s2_valid <= s1_valid;
        end
        // stage 1 partial products
        s1_lane <= sel_lane;
        pp_ll   <= a_lo * b_lo;
        pp_lh   <= a_lo * b_hi;
        pp_hl   <= a_hi * b_lo;
        pp_hh   <= a_hi * b_hi;
        // stage 2 keeps the low word
        s2_lane <= s1_lane;
        product <= sum[data_w-1:0];
    end

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            mul_product[l] = (s2_valid && s2_lane == 1'(l)) ? product : '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/operand_bypass.sv */
`default_nettype none

module operand_bypass (
    input  wire logic [issue_pkg::reg_idx_w-1:0] cand_rs1  [1:0],
    input  wire logic [issue_pkg::reg_idx_w-1:0] cand_rs2  [1:0],
    input  wire logic [issue_pkg::data_w-1:0]    rf_rdata  [3:0],
    input  wire logic [1:0]                      ex_valid,
    input  wire logic [issue_pkg::reg_idx_w-1:0] ex_rd     [1:0],
    input  wire logic [1:0]                      ex_wen,
    input  wire logic [issue_pkg::data_w-1:0]    ex_result [1:0],
    input  wire logic [1:0]                      ex_is_mul,
    input  wire logic [1:0]                      wb_valid,
    input  wire logic [issue_pkg::reg_idx_w-1:0] wb_rd     [1:0],
    input  wire logic [1:0]                      wb_wen,
    input  wire logic [issue_pkg::data_w-1:0]    wb_value  [1:0],
    output logic [1:0]                           cand_ready,
    output logic [issue_pkg::data_w-1:0]         opnd_a    [1:0],
    output logic [issue_pkg::data_w-1:0]         opnd_b    [1:0]
);
    import issue_pkg::*;

    // operand k: 2*lane is rs1, 2*lane+1 is rs2
    logic [reg_idx_w-1:0] src_addr [3:0];
    logic [data_w-1:0]    src_data [3:0];
    logic [3:0]           src_busy;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            src_addr[2*i]   = cand_rs1[i];
            src_addr[2*i+1] = cand_rs2[i];
        end
        for (int k = 0; k < 4; k++) begin
            src_data[k] = rf_rdata[k];
            src_busy[k] = 1'b0;
            // later assignments win, lane 0 last within a stage
            for (int l = 1; l >= 0; l--) begin
                if (wb_valid[l] && wb_wen[l] && wb_rd[l] == src_addr[k]) begin
                    src_data[k] = wb_value[l];
                end
            end
            for (int l = 1; l >= 0; l--) begin
                if (ex_valid[l] && ex_wen[l] && ex_rd[l] == src_addr[k]) begin
                    // product only exists from writeback on
                    if (ex_is_mul[l]) begin
                        src_busy[k] = 1'b1;
                    end else begin
                        src_data[k] = ex_result[l];
                    end
                end
            end
        end
        for (int i = 0; i < 2; i++) begin
            cand_ready[i] = !src_busy[2*i] && !src_busy[2*i+1];
            opnd_a[i]     = src_data[2*i];
            opnd_b[i]     = src_data[2*i+1];
        end
    end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`default_nettype none

module reg_file (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic [issue_pkg::reg_idx_w-1:0] raddr [3:0],
    input  wire logic [1:0]                      we,
    input  wire logic [issue_pkg::reg_idx_w-1:0] waddr [1:0],
    input  wire logic [issue_pkg::data_w-1:0]    wdata [1:0],
    output logic [issue_pkg::data_w-1:0]         rdata [3:0]
);
    import issue_pkg::*;

    logic [data_w-1:0] regs [reg_count];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < reg_count; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // younger lane 0 written last so it wins
            for (int l = 1; l >= 0; l--) begin
                if (we[l] && waddr[l] != '0) begin
                    regs[waddr[l]] <= wdata[l];
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rdata[k] = (raddr[k] == '0) ? '0 : regs[raddr[k]];
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f src.f --top-module issue_tb -o issue_sim &&
./obj_dir/issue_sim | tee /dev/stderr | grep -qx "PASS: all tests" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* src.f */
hdl/issue_pkg.sv
hdl/reg_file.sv
hdl/operand_bypass.sv
hdl/exec_lane.sv
hdl/mul_unit.sv
hdl/issue_queue.sv
hdl/issue_core.sv
verif/issue_checker.sv
verif/issue_tb.sv

/* verif/issue_checker.sv */
`default_nettype none

module issue_checker (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            flush,
    input  wire logic [1:0]                      in_valid,
    input  wire issue_pkg::op_e                  in_op     [1:0],
    input  wire logic [issue_pkg::reg_idx_w-1:0] in_rd     [1:0],
    input  wire logic [issue_pkg::reg_idx_w-1:0] in_rs1    [1:0],
    input  wire logic [issue_pkg::reg_idx_w-1:0] in_rs2    [1:0],
    input  wire logic [issue_pkg::imm_w-1:0]     in_imm    [1:0],
    input  wire logic [issue_pkg::tag_w-1:0]     in_tag    [1:0],
    input  wire logic                            in_ready,
    input  wire logic [1:0]                      ret_valid,
    input  wire logic [issue_pkg::tag_w-1:0]     ret_tag   [1:0],
    input  wire logic [issue_pkg::reg_idx_w-1:0] ret_rd    [1:0],
    input  wire logic [1:0]                      ret_wen,
    input  wire logic [issue_pkg::data_w-1:0]    ret_value [1:0],
    output int                                   mismatch_count,
    output int                                   order_count,
    output int                                   pair_count,
    output int                                   flow_count,
    output int                                   outstanding
);
    timeunit 1ns;
    timeprecision 100ps;
    import issue_pkg::*;

    typedef struct {
        op_e                  op;
        logic [reg_idx_w-1:0] rd;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [imm_w-1:0]     imm;
        logic [tag_w-1:0]     tag;
        bit                   flushable;
    } op_rec_t;

    // accepted but not yet retired, in program order
    op_rec_t           pending [$];
    logic [data_w-1:0] model_regs [reg_count];
    bit                after_rst = 1'b0;
    int                n_mismatch = 0;
    int                n_order = 0;
    int                n_pair = 0;
    int                n_flow = 0;

    assign mismatch_count = n_mismatch;
    assign order_count    = n_order;
    assign pair_count     = n_pair;
    assign flow_count     = n_flow;

    function automatic logic [data_w-1:0] expected_value(op_rec_t rec, logic [data_w-1:0] a,
                                                         logic [data_w-1:0] b);
        logic [data_w-1:0] sext;
        sext = {{(data_w - imm_w){rec.imm[imm_w-1]}}, rec.imm};
        case (rec.op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_addi: return a + sext;
            op_lui:  return {rec.imm, {(data_w - imm_w){1'b0}}};
            op_mul:  return a * b;
            default: return '0;
        endcase
    endfunction

    function automatic bit has_dest(op_rec_t rec);
        return rec.op != op_nop && rec.rd != '0;
    endfunction

    function automatic logic [data_w-1:0] model_read(logic [reg_idx_w-1:0] r);
        return (r == '0) ? '0 : model_regs[r];
    endfunction

    function automatic int count_live();
        int n;
        n = 0;
        foreach (pending[i]) begin
            if (!pending[i].flushable) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [tag_w-1:0] tag,
                               input logic [data_w-1:0] expected,
                               input logic [data_w-1:0] actual);
        if (expected !== actual) begin
            n_mismatch++;
            $display("mismatch %s tag %0d: expected %h actual %h", name, tag, expected, actual);
        end
    endtask

    // runs one retired op through the model
    task automatic retire_lane(input int lane, output bit found, output op_rec_t rec);
        logic [data_w-1:0] exp_value;
        found = 1'b0;
        // flushed ops ahead of it were dropped by the queue
        while (pending.size() > 0 && pending[0].tag != ret_tag[lane] && pending[0].flushable) begin
            void'(pending.pop_front());
        end
        if (pending.size() == 0 || pending[0].tag != ret_tag[lane]) begin
            n_order++;
            $display("order error at %0t: lane %0d retired tag %0d out of program order",
                     $time, lane, ret_tag[lane]);
        end else begin
            rec = pending.pop_front();
            found = 1'b1;
            exp_value = expected_value(rec, model_read(rec.rs1), model_read(rec.rs2));
            check_value("ret_value", rec.tag, exp_value, ret_value[lane]);
            check_value("ret_rd", rec.tag, data_w'(rec.rd), data_w'(ret_rd[lane]));
            check_value("ret_wen", rec.tag, data_w'(has_dest(rec)), data_w'(ret_wen[lane]));
            if (has_dest(rec)) begin
                model_regs[rec.rd] = exp_value;
            end
        end
    endtask

    task automatic check_pair(input op_rec_t older, input op_rec_t younger);
        if (older.op == op_mul && younger.op == op_mul) begin
            n_pair++;
            $display("pairing error at %0t: tags %0d and %0d both multiply in one cycle",
                     $time, older.tag, younger.tag);
        end
        if (has_dest(older) && (younger.rs1 == older.rd || younger.rs2 == older.rd)) begin
            n_pair++;
            $display("pairing error at %0t: tag %0d reads r%0d written by tag %0d in one cycle",
                     $time, younger.tag, older.rd, older.tag);
        end
    endtask

    always @(posedge clk) begin
        bit      found1;
        bit      found0;
        op_rec_t rec1;
        op_rec_t rec0;
        op_rec_t acc;
        if (rst) begin
            pending.delete();
            for (int r = 0; r < reg_count; r++) begin
                model_regs[r] = '0;
            end
            after_rst = 1'b1;
            outstanding = 0;
        end else begin
            if (after_rst && (!in_ready || ret_valid != 2'b00)) begin
                n_flow++;
                $display("reset state wrong: in_ready %b ret_valid %b", in_ready, ret_valid);
            end
            after_rst = 1'b0;
            // queue entries are a subset of what is in flight
            if (!in_ready && pending.size() < queue_depth - 1) begin
                n_flow++;
                $display("flow error at %0t: in_ready low with %0d operations in flight",
                         $time, pending.size());
            end
            found1 = 1'b0;
            found0 = 1'b0;
            if (ret_valid[1]) begin
                retire_lane(1, found1, rec1);
            end
            if (ret_valid[0]) begin
                if (!ret_valid[1]) begin
                    n_order++;
                    $display("order error at %0t: lane 0 retired without lane 1", $time);
                end
                retire_lane(0, found0, rec0);
            end
            if (found1 && found0) begin
                check_pair(rec1, rec0);
            end
            if (flush) begin
                foreach (pending[i]) begin
                    pending[i].flushable = 1'b1;
                end
            end
            if (in_ready) begin
                for (int s = 1; s >= 0; s--) begin
                    if (in_valid[s]) begin
                        acc.op = in_op[s];
                        acc.rd = in_rd[s];
                        acc.rs1 = in_rs1[s];
                        acc.rs2 = in_rs2[s];
                        acc.imm = in_imm[s];
                        acc.tag = in_tag[s];
                        acc.flushable = 1'b0;
                        pending.push_back(acc);
                    end
                end
            end
            outstanding = count_live();
        end
    end

endmodule

`default_nettype wire

/* verif/issue_tb.sv */
`default_nettype none

module issue_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import issue_pkg::*;

    localparam int clk_period  = 100;
    localparam int n_pairs     = 2000;
    // 20 periods for each possible operation
    localparam int watchdog_ns = 20 * 2 * n_pairs * clk_period;

    logic                 clk;
    logic                 rst;
    logic                 flush;
    logic [1:0]           in_valid;
    op_e                  in_op     [1:0];
    logic [reg_idx_w-1:0] in_rd     [1:0];
    logic [reg_idx_w-1:0] in_rs1    [1:0];
    logic [reg_idx_w-1:0] in_rs2    [1:0];
    logic [imm_w-1:0]     in_imm    [1:0];
    logic [tag_w-1:0]     in_tag    [1:0];
    logic                 in_ready;
    logic [1:0]           ret_valid;
    logic [tag_w-1:0]     ret_tag   [1:0];
    logic [reg_idx_w-1:0] ret_rd    [1:0];
    logic [1:0]           ret_wen;
    logic [data_w-1:0]    ret_value [1:0];

    int                   mismatch_count;
    int                   order_count;
    int                   pair_count;
    int                   flow_count;
    int                   outstanding;
    int                   cycle = 0;
    int                   next_flush;
    logic [tag_w-1:0]     next_tag;

    issue_core dut0 (
        .clk, .rst, .flush,
        .in_valid, .in_op, .in_rd, .in_rs1, .in_rs2, .in_imm, .in_tag,
        .in_ready,
        .ret_valid, .ret_tag, .ret_rd, .ret_wen, .ret_value
    );

    issue_checker chk0 (
        .clk, .rst, .flush,
        .in_valid, .in_op, .in_rd, .in_rs1, .in_rs2, .in_imm, .in_tag,
        .in_ready,
        .ret_valid, .ret_tag, .ret_rd, .ret_wen, .ret_value,
        .mismatch_count, .order_count, .pair_count, .flow_count, .outstanding
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic op_e pick_op();
        if ($urandom_range(0, 99) < 20) begin
            return op_mul;
        end
        return op_e'(4'($urandom_range(0, 7)));
    endfunction

    // small register range keeps dependences frequent
    task automatic load_slot(input int s);
        in_op[s]  = pick_op();
        in_rd[s]  = reg_idx_w'($urandom_range(0, 7));
        in_rs1[s] = reg_idx_w'($urandom_range(0, 7));
        in_rs2[s] = reg_idx_w'($urandom_range(0, 7));
        in_imm[s] = imm_w'($urandom);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
        end
    endtask

    // inputs held until the queue takes them
    task automatic send_pair();
        bit taken;
        bit single;
        single = ($urandom_range(0, 99) < 20);
        load_slot(1);
        load_slot(0);
        in_tag[1] = next_tag;
        in_tag[0] = next_tag + 1'b1;
        in_valid  = single ? 2'b10 : 2'b11;
        do begin
            // in_ready only depends on registered occupancy
            taken = in_ready;
            @(posedge clk);
            #5;
        end while (!taken);
        next_tag = next_tag + (single ? tag_w'(1) : tag_w'(2));
        in_valid = 2'b00;
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge clk);
        #5;
        flush = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h36f50061));
        rst      = 1'b1;
        flush    = 1'b0;
        in_valid = 2'b00;
        next_tag = '0;
        for (int s = 0; s < 2; s++) begin
            in_op[s]  = op_nop;
            in_rd[s]  = '0;
            in_rs1[s] = '0;
            in_rs2[s] = '0;
            in_imm[s] = '0;
            in_tag[s] = '0;
        end
        repeat (3) @(posedge clk);
        #5;
        rst = 1'b0;
        next_flush = cycle + int'($urandom_range(130, 170));
        for (int i = 0; i < n_pairs; i++) begin
            send_pair();
            wait_cycles($urandom_range(0, 2));
            if (cycle >= next_flush) begin
                pulse_flush();
                next_flush = cycle + int'($urandom_range(130, 170));
            end
        end
        // drain whatever was not flushed
        while (outstanding != 0) begin
            @(posedge clk);
            #5;
        end
        wait_cycles(2);
        $display("errors: mismatch %0d, order %0d, pairing %0d, flow %0d",
                 mismatch_count, order_count, pair_count, flow_count);
        if (mismatch_count + order_count + pair_count + flow_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: run passed %0d ns with %0d accepted operations not retired",
                 watchdog_ns, outstanding);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
